// File: istore_trace.txt
# W addr beats burst, then data per beat, strobe per beat, response
# R addr beats burst, then data per beat, response per beat; D index data; E end; all hex
W 00000000 10 1
10000000 10000001 10000002 10000003 10000004 10000005 10000006 10000007
10000008 10000009 1000000a 1000000b 1000000c 1000000d 1000000e 1000000f
f f f f f f f f f f f f f f f f
0
R 00000000 10 1
10000000 10000001 10000002 10000003 10000004 10000005 10000006 10000007
10000008 10000009 1000000a 1000000b 1000000c 1000000d 1000000e 1000000f
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
D 01 10000001
D 05 10000005
D 0f 1000000f
D 00 10000000
D 0a 1000000a
W 00000008 1 1 aabbccdd 5 0
R 00000008 1 1 10bb00dd 0
W 00000040 4 0 11111111 22222222 33333333 44444444 f f f f 0
R 00000040 3 0 44444444 44444444 44444444 0 0 0
W 000003f8 4 1 a0000001 a0000002 a0000003 a0000004 f f f f 2
R 000003f8 4 1 a0000001 a0000002 00000000 00000000 0 0 2 2
W 00000000 2 2 deadbeef deadbeef f f 2
R 00000000 2 1 10000000 10000001 0 0
R 00000004 1 2 00000000 2
D 02 10bb00dd
D 10 44444444
D fe a0000001
D ff a0000002
D 03 10000003
E

// File: all.f
axi_pkg.sv
istore_pkg.sv
istore_wr_if.sv
istore_mem.sv
axi_write_ctrl.sv
axi_read_ctrl.sv
fcore_istore.sv
tb_clock_gen.sv
tb_istore_checker.sv
tb_fcore_istore.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator from the project root.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f all.f --top-module tb_fcore_istore -o tb_sim > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/tb_sim > sim.log 2>&1
cat sim.log

grep -qx "TEST OK" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: tb_fcore_istore.sv
module tb_fcore_istore;

    logic                                clock;
    logic                                rst_n;
    logic [axi_pkg::axi_addr_w-1:0]      awaddr;
    logic [axi_pkg::axi_len_w-1:0]       awlen;
    logic [1:0]                          awburst;
    logic                                awvalid;
    logic                                awready;
    logic [axi_pkg::axi_data_w-1:0]      wdata;
    logic [axi_pkg::axi_strb_w-1:0]      wstrb;
    logic                                wlast;
    logic                                wvalid;
    logic                                wready;
    logic [1:0]                          bresp;
    logic                                bvalid;
    logic                                bready;
    logic [axi_pkg::axi_addr_w-1:0]      araddr;
    logic [axi_pkg::axi_len_w-1:0]       arlen;
    logic [1:0]                          arburst;
    logic                                arvalid;
    logic                                arready;
    logic [axi_pkg::axi_data_w-1:0]      rdata;
    logic [1:0]                          rresp;
    logic                                rlast;
    logic                                rvalid;
    logic                                rready;
    logic [istore_pkg::istore_idx_w-1:0] dma_read_addr;
    logic [axi_pkg::axi_data_w-1:0]      dma_read_data;
    logic                                dma_valid;

    logic [31:0]  w_data [256];
    logic [3:0]   w_strb [256];
    logic [31:0]  r_words [256];
    logic [31:0]  rd_addr;       // Command of the background read.
    int           rd_beats;
    logic [1:0]   rd_burst;
    logic [15:0]  lfsr = 16'd46698;
    logic         read_busy = 1'b0;
    int           trace_lines = 0;
    int           tb_errors = 0;

    tb_clock_gen clock_gen_i (.clock(clock), .rst_n(rst_n));

    fcore_istore fcore_istore_i (.*);

    tb_istore_checker checker_i (.*);

    initial begin
        awaddr = '0;
        awlen = '0;
        awburst = '0;
        awvalid = 1'b0;
        wdata = '0;
        wstrb = '0;
        wlast = 1'b0;
        wvalid = 1'b0;
        araddr = '0;
        arlen = '0;
        arburst = '0;
        arvalid = 1'b0;
        bready = 1'b0;
        rready = 1'b0;
        dma_read_addr = '0;
        dma_valid = 1'b0;
    end

    // Galois LFSR, taps for x^16 + x^14 + x^13 + x^11 + 1.
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // --------------------
    // Back-pressure
    // --------------------
    always @(posedge clock) begin
        #2;
        bready = lfsr[0];
        lfsr = lfsr_next(lfsr);
        rready = lfsr[0];
        lfsr = lfsr_next(lfsr);
    end

    task automatic run_write(input logic [31:0] addr, input int beats, input logic [1:0] burst);
        awaddr  = addr;
        awlen   = 8'(beats - 1);
        awburst = burst;
        awvalid = 1'b1;
        do @(posedge clock); while (!awready);
        #2 awvalid = 1'b0;
        for (int i = 0; i < beats; i++) begin
            wdata  = w_data[i];
            wstrb  = w_strb[i];
            wlast  = i == beats - 1;
            wvalid = 1'b1;
            do @(posedge clock); while (!wready);
            #2;
        end
        wvalid = 1'b0;
        wlast  = 1'b0;
        do @(posedge clock); while (!(bvalid && bready));
        #2;
    endtask

    // Runs in the background so D commands can overlap the burst.
    task automatic run_read(input logic [31:0] addr, input int beats, input logic [1:0] burst);
        araddr  = addr;
        arlen   = 8'(beats - 1);
        arburst = burst;
        arvalid = 1'b1;
        do @(posedge clock); while (!arready);
        #2 arvalid = 1'b0;
        do @(posedge clock); while (!(rvalid && rready && rlast));
        #2 read_busy = 1'b0;
    endtask

    // --------------------
    // Watchdog
    // --------------------
    initial begin
        wait (trace_lines > 0);
        repeat (40 * trace_lines + 5) @(posedge clock);
        $display("watchdog expired before the trace finished");
        $display("TEST FAILED");
        $finish;
    end

    // --------------------
    // Trace player
    // --------------------
    initial begin
        int          fd;
        int          code;
        int          beats;
        logic [7:0]  kind;
        logic [31:0] addr;
        logic [31:0] val;
        logic [1:0]  burst;
        logic [8*256-1:0] line_buf;
        bit          done;
        fd = $fopen("istore_trace.txt", "r");
        if (fd == 0) begin
            $display("cannot open istore_trace.txt");
            tb_errors++;
        end else begin
            while (!$feof(fd)) begin
                code = $fgets(line_buf, fd);
                if (code > 0) trace_lines++;
            end
            $fclose(fd);
            fd = $fopen("istore_trace.txt", "r");
            wait (rst_n);
            @(posedge clock);
            #2;
            done = 1'b0;
            while (!done) begin
                code = $fscanf(fd, " %c", kind);
                if (code != 1) begin
                    $display("trace ended without an E line");
                    tb_errors++;
                    done = 1'b1;
                end else begin
                    case (kind)
                        "#": code = $fgets(line_buf, fd);
                        "W": begin
                            wait (!read_busy);
                            code = $fscanf(fd, " %h %h %h", addr, beats, burst);
                            for (int i = 0; i < beats; i++) code = $fscanf(fd, " %h", w_data[i]);
                            for (int i = 0; i < beats; i++) code = $fscanf(fd, " %h", w_strb[i]);
                            code = $fscanf(fd, " %h", val);
                            checker_i.expect_b(val[1:0]);
                            run_write(addr, beats, burst);
                        end
                        "R": begin
                            wait (!read_busy);
                            code = $fscanf(fd, " %h %h %h", addr, beats, burst);
                            for (int i = 0; i < beats; i++) code = $fscanf(fd, " %h", r_words[i]);
                            for (int i = 0; i < beats; i++) begin
                                code = $fscanf(fd, " %h", val);
                                checker_i.expect_r(r_words[i], val[1:0], i == beats - 1);
                            end
                            rd_addr   = addr;
                            rd_beats  = beats;
                            rd_burst  = burst;
                            read_busy = 1'b1;
                            fork
                                run_read(rd_addr, rd_beats, rd_burst);
                            join_none
                        end
                        "D": begin
                            code = $fscanf(fd, " %h %h", addr, val);
                            checker_i.expect_dma(val);
                            dma_read_addr = addr[istore_pkg::istore_idx_w-1:0];
                            dma_valid = 1'b1;
                            @(posedge clock);
                            #2 dma_valid = 1'b0;
                        end
                        "E": done = 1'b1;
                        default: begin
                            $display("unknown command in trace: %c", kind);
                            tb_errors++;
                            done = 1'b1;
                        end
                    endcase
                end
            end
            $fclose(fd);
            wait (!read_busy);
            repeat (4) @(posedge clock);
            if (checker_i.pending_count() != 0) begin
                $display("%0d expected responses never arrived", checker_i.pending_count());
                tb_errors++;
            end
        end
        $display("errors: value %0d, protocol %0d, trace %0d",
                 checker_i.value_errors, checker_i.protocol_errors, tb_errors);
        if (checker_i.value_errors + checker_i.protocol_errors + tb_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule : tb_fcore_istore

// File: tb_istore_checker.sv
module tb_istore_checker (
    input logic                                clock,
    input logic                                rst_n,
    input logic                                awvalid,
    input logic                                awready,
    input logic                                wvalid,
    input logic                                wready,
    input logic                                wlast,
    input logic [1:0]                          bresp,
    input logic                                bvalid,
    input logic                                bready,
    input logic                                arvalid,
    input logic                                arready,
    input logic [axi_pkg::axi_data_w-1:0]      rdata,
    input logic [1:0]                          rresp,
    input logic                                rlast,
    input logic                                rvalid,
    input logic                                rready,
    input logic                                dma_valid,
    input logic [axi_pkg::axi_data_w-1:0]      dma_read_data
);

    logic [1:0]                     exp_b [$];
    logic [axi_pkg::axi_data_w-1:0] exp_r_data [$];
    logic [1:0]                     exp_r_resp [$];
    logic                           exp_r_last [$];
    logic [axi_pkg::axi_data_w-1:0] exp_dma [$];

    int   value_errors = 0;
    int   protocol_errors = 0;
    logic dma_pending = 1'b0;    // A DMA address was sampled last edge.

    // Bus phases seen at the handshakes.
    logic settled = 1'b0;        // Ready outputs are idle one edge after reset.
    logic aw_open = 1'b0;        // AW taken, B not yet.
    logic w_open  = 1'b0;        // AW taken, W with wlast not yet.
    logic ar_open = 1'b0;        // AR taken, R with rlast not yet.

    task automatic expect_b(input logic [1:0] resp);
        exp_b.push_back(resp);
    endtask

    task automatic expect_r(input logic [31:0] data, input logic [1:0] resp, input logic last);
        exp_r_data.push_back(data);
        exp_r_resp.push_back(resp);
        exp_r_last.push_back(last);
    endtask

    task automatic expect_dma(input logic [31:0] data);
        exp_dma.push_back(data);
    endtask

    function automatic int pending_count();
        return exp_b.size() + exp_r_data.size() + exp_dma.size();
    endfunction

    task automatic report_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        $display("[ERROR] %0t %s expected %h got %h", $time, name, exp, act);
        value_errors++;
    endtask

    // --------------------
    // Compare on each edge
    // --------------------
    always @(posedge clock) begin
        logic [31:0] e_data;
        logic [1:0]  e_resp;
        logic        e_last;
        if (rst_n) begin
            if (settled) begin
                if (awready != !aw_open) report_value("awready", 32'(!aw_open), 32'(awready));
                if (wready != w_open) report_value("wready", 32'(w_open), 32'(wready));
                if (arready != !ar_open) report_value("arready", 32'(!ar_open), 32'(arready));
            end
            if (bvalid && bready) begin
                if (exp_b.size() == 0) begin
                    $display("%0t a write response arrived with no write outstanding", $time);
                    protocol_errors++;
                end else begin
                    e_resp = exp_b.pop_front();
                    if (bresp != e_resp) report_value("bresp", 32'(e_resp), 32'(bresp));
                end
            end
            if (rvalid && rready) begin
                if (exp_r_data.size() == 0) begin
                    $display("%0t a read beat arrived with no read outstanding", $time);
                    protocol_errors++;
                end else begin
                    e_data = exp_r_data.pop_front();
                    e_resp = exp_r_resp.pop_front();
                    e_last = exp_r_last.pop_front();
                    if (rdata != e_data) report_value("rdata", e_data, rdata);
                    if (rresp != e_resp) report_value("rresp", 32'(e_resp), 32'(rresp));
                    if (rlast != e_last) begin
                        if (e_last) $display("%0t rlast is missing on the last beat", $time);
                        else $display("%0t rlast came early in a read burst", $time);
                        protocol_errors++;
                    end
                end
            end
            if (dma_pending) begin
                e_data = exp_dma.pop_front();
                if (dma_read_data != e_data) report_value("dma_read_data", e_data, dma_read_data);
            end
            dma_pending = dma_valid;
            if (awvalid && awready) begin
                aw_open = 1'b1;
                w_open  = 1'b1;
            end
            if (wvalid && wready && wlast) begin
                w_open = 1'b0;
            end
            if (bvalid && bready) begin
                aw_open = 1'b0;
            end
            if (arvalid && arready) begin
                ar_open = 1'b1;
            end
            if (rvalid && rready && rlast) begin
                ar_open = 1'b0;
            end
            settled = 1'b1;
        end
    end

endmodule : tb_istore_checker

// File: tb_clock_gen.sv
module tb_clock_gen (
    output logic clock,
    output logic rst_n
);

    initial begin
        clock = 1'b0;
        forever #10 clock = !clock;    // Period 20.
    end

    initial begin
        rst_n = 1'b0;
        repeat (5) @(posedge clock);
        #2 rst_n = 1'b1;               // Released off the edge like other inputs.
    end

endmodule : tb_clock_gen

// File: fcore_istore.sv
module fcore_istore (
    input  logic                                clock,
    input  logic                                rst_n,
    // AXI write address
    input  logic [axi_pkg::axi_addr_w-1:0]      awaddr,
    input  logic [axi_pkg::axi_len_w-1:0]       awlen,
    input  logic [1:0]                          awburst,
    input  logic                                awvalid,
    output logic                                awready,
    // AXI write data
    input  logic [axi_pkg::axi_data_w-1:0]      wdata,
    input  logic [axi_pkg::axi_strb_w-1:0]      wstrb,
    input  logic                                wlast,    // Burst end comes from awlen.
    input  logic                                wvalid,
    output logic                                wready,
    // AXI write response
    output logic [1:0]                          bresp,
    output logic                                bvalid,
    input  logic                                bready,
    // AXI read address
    input  logic [axi_pkg::axi_addr_w-1:0]      araddr,
    input  logic [axi_pkg::axi_len_w-1:0]       arlen,
    input  logic [1:0]                          arburst,
    input  logic                                arvalid,
    output logic                                arready,
    // AXI read data
    output logic [axi_pkg::axi_data_w-1:0]      rdata,
    output logic [1:0]                          rresp,
    output logic                                rlast,
    output logic                                rvalid,
    input  logic                                rready,
    // DMA read port
    input  logic [istore_pkg::istore_idx_w-1:0] dma_read_addr,
    output logic [axi_pkg::axi_data_w-1:0]      dma_read_data
);

    logic                                rd_en;
    logic [istore_pkg::istore_idx_w-1:0] rd_idx;
    logic [axi_pkg::axi_data_w-1:0]      rd_data;

    istore_wr_if wr_bus ();

    axi_write_ctrl axi_write_ctrl_i (
        .clock   (clock),
        .rst_n   (rst_n),
        .awaddr  (awaddr),
        .awlen   (awlen),
        .awburst (awburst),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .wr      (wr_bus.src)
    );

    istore_mem istore_mem_i (
        .clock    (clock),
        .wr       (wr_bus.mem),
        .rd_en    (rd_en),
        .rd_idx   (rd_idx),
        .rd_data  (rd_data),
        .dma_idx  (dma_read_addr),
        .dma_data (dma_read_data)
    );

    axi_read_ctrl axi_read_ctrl_i (
        .clock   (clock),
        .rst_n   (rst_n),
        .araddr  (araddr),
        .arlen   (arlen),
        .arburst (arburst),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rlast   (rlast),
        .rvalid  (rvalid),
        .rready  (rready),
        .rd_en   (rd_en),
        .rd_idx  (rd_idx),
        .rd_data (rd_data)
    );

endmodule : fcore_istore

// File: axi_read_ctrl.sv
module axi_read_ctrl (
    input  logic                                clock,
    input  logic                                rst_n,
    input  logic [axi_pkg::axi_addr_w-1:0]      araddr,
    input  logic [axi_pkg::axi_len_w-1:0]       arlen,
    input  logic [1:0]                          arburst,
    input  logic                                arvalid,
    output logic                                arready,
    output logic [axi_pkg::axi_data_w-1:0]      rdata,
    output logic [1:0]                          rresp,
    output logic                                rlast,
    output logic                                rvalid,
    input  logic                                rready,
    output logic                                rd_en,
    output logic [istore_pkg::istore_idx_w-1:0] rd_idx,
    input  logic [axi_pkg::axi_data_w-1:0]      rd_data
);

    // Issue side.
    logic                           busy;          // Between AR and the last R.
    logic                           issuing;
    logic [axi_pkg::axi_addr_w-1:0] raddr;
    logic [axi_pkg::axi_len_w-1:0]  issue_left;
    logic                           incr;
    logic                           bad_burst;

    // Beat in the memory this cycle.
    logic pend_valid;
    logic pend_err;
    logic pend_last;

    // Two-entry output buffer.
    logic [axi_pkg::axi_data_w-1:0] buf_data [2];
    logic [1:0]                     buf_err;
    logic [1:0]                     buf_last;
    logic                           buf_wptr;
    logic                           buf_rptr;
    logic [1:0]                     buf_cnt;

    logic       ar_fire;
    logic       r_fire;
    logic       issue;
    logic       beat_err;
    logic       beat_last;
    logic [1:0] used;

    assign ar_fire   = arvalid && arready;
    assign r_fire    = rvalid && rready;
    assign beat_err  = bad_burst || raddr >= istore_pkg::istore_byte_limit;
    assign beat_last = issue_left == '0;

    // Buffered plus in flight never exceeds two.
    assign used  = buf_cnt + {1'b0, pend_valid};
    assign issue = issuing && (used != 2'd2 || r_fire);

    assign rd_en  = issue;
    assign rd_idx = raddr[istore_pkg::istore_idx_w+1:2];

    assign rvalid = buf_cnt != 2'd0;
    assign rdata  = buf_data[buf_rptr];
    assign rresp  = buf_err[buf_rptr] ? axi_pkg::resp_slverr : axi_pkg::resp_okay;
    assign rlast  = buf_last[buf_rptr];

    // --------------------
    // Control
    // --------------------
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            arready    <= 1'b0;
            busy       <= 1'b0;
            issuing    <= 1'b0;
            pend_valid <= 1'b0;
            buf_last   <= '0;
            buf_wptr   <= 1'b0;
            buf_rptr   <= 1'b0;
            buf_cnt    <= '0;
        end else begin
            if (ar_fire) begin
                arready <= 1'b0;
                busy    <= 1'b1;
                issuing <= 1'b1;
            end else if (r_fire && rlast) begin
                busy    <= 1'b0;
                arready <= 1'b1;
            end else if (!busy) begin
                arready <= 1'b1;    // Leave reset into idle.
            end
            if (issue && beat_last) begin
                issuing <= 1'b0;    // All beats issued.
            end
            pend_valid <= issue;
            if (pend_valid) begin
                buf_last[buf_wptr] <= pend_last;
                buf_wptr           <= !buf_wptr;
            end
            if (r_fire) begin
                buf_rptr <= !buf_rptr;
            end
            buf_cnt <= buf_cnt + {1'b0, pend_valid} - {1'b0, r_fire};
        end
    end

    // --------------------
    // Datapath
    // --------------------
    always_ff @(posedge clock) begin
        if (ar_fire) begin
            raddr      <= araddr;
            issue_left <= arlen;
            incr       <= arburst == axi_pkg::burst_incr;
            bad_burst  <= arburst != axi_pkg::burst_incr && arburst != axi_pkg::burst_fixed;
        end else if (issue) begin
            if (incr) begin
                raddr <= raddr + axi_pkg::axi_strb_w;
            end
            issue_left <= issue_left - 1'b1;
        end
        if (issue) begin
            pend_err  <= beat_err;      // Tag travels with the read.
            pend_last <= beat_last;
        end
        if (pend_valid) begin
            buf_data[buf_wptr] <= pend_err ? '0 : rd_data;
            buf_err[buf_wptr]  <= pend_err;
        end
    end

endmodule : axi_read_ctrl

// File: axi_write_ctrl.sv
module axi_write_ctrl (
    input  logic                           clock,
    input  logic                           rst_n,
    input  logic [axi_pkg::axi_addr_w-1:0] awaddr,
    input  logic [axi_pkg::axi_len_w-1:0]  awlen,
    input  logic [1:0]                     awburst,
    input  logic                           awvalid,
    output logic                           awready,
    input  logic [axi_pkg::axi_data_w-1:0] wdata,
    input  logic [axi_pkg::axi_strb_w-1:0] wstrb,
    input  logic                           wvalid,
    output logic                           wready,
    output logic [1:0]                     bresp,
    output logic                           bvalid,
    input  logic                           bready,
    istore_wr_if.src                       wr
);

    logic [axi_pkg::axi_addr_w-1:0] addr;          // Byte address of the next beat.
    logic [axi_pkg::axi_len_w-1:0]  beats_left;    // Beats after the current one.
    logic                           incr;
    logic                           bad_burst;
    logic                           err;

    logic aw_fire;
    logic w_fire;
    logic b_fire;
    logic in_range;
    logic last_beat;

    assign aw_fire   = awvalid && awready;
    assign w_fire    = wvalid && wready;
    assign b_fire    = bvalid && bready;
    assign in_range  = addr < istore_pkg::istore_byte_limit;
    assign last_beat = beats_left == '0;

    // --------------------
    // Memory write
    // --------------------
    assign wr.en   = w_fire && in_range && !bad_burst;
    assign wr.idx  = addr[istore_pkg::istore_idx_w+1:2];
    assign wr.data = wdata;
    assign wr.strb = wstrb;

    assign bresp = err ? axi_pkg::resp_slverr : axi_pkg::resp_okay;

    // --------------------
    // FSM
    // --------------------
    // One-hot: idle is awready, data is wready, response is bvalid.
    // All three low only right after reset.
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
        end else if (aw_fire) begin
            awready <= 1'b0;
            wready  <= 1'b1;
        end else if (w_fire && last_beat) begin
            wready <= 1'b0;
            bvalid <= 1'b1;    // Length count ends the burst.
        end else if (b_fire) begin
            bvalid  <= 1'b0;
            awready <= 1'b1;
        end else if (!wready && !bvalid) begin
            awready <= 1'b1;   // Leave reset into idle.
        end
    end

    // Burst bookkeeping.
    always_ff @(posedge clock) begin
        if (aw_fire) begin
            addr       <= awaddr;
            beats_left <= awlen;
            incr       <= awburst == axi_pkg::burst_incr;
            bad_burst  <= awburst != axi_pkg::burst_incr && awburst != axi_pkg::burst_fixed;
            err        <= awburst != axi_pkg::burst_incr && awburst != axi_pkg::burst_fixed;
        end else if (w_fire) begin
            if (incr) begin
                addr <= addr + axi_pkg::axi_strb_w;    // Next word.
            end
            beats_left <= beats_left - 1'b1;
            if (!in_range) begin
                err <= 1'b1;                           // Beat dropped.
            end
        end
    end

endmodule : axi_write_ctrl

// File: istore_mem.sv
module istore_mem (
    input  logic                                clock,
    istore_wr_if.mem                            wr,
    input  logic                                rd_en,
    input  logic [istore_pkg::istore_idx_w-1:0] rd_idx,
    output logic [axi_pkg::axi_data_w-1:0]      rd_data,
    input  logic [istore_pkg::istore_idx_w-1:0] dma_idx,
    output logic [axi_pkg::axi_data_w-1:0]      dma_data
);

    logic [axi_pkg::axi_data_w-1:0] mem [istore_pkg::istore_depth];

    // --------------------
    // Write port
    // --------------------
    always_ff @(posedge clock) begin
        if (wr.en) begin
            for (int b = 0; b < axi_pkg::axi_strb_w; b++) begin
                if (wr.strb[b]) begin
                    mem[wr.idx][8*b +: 8] <= wr.data[8*b +: 8];    // Only enabled lanes.
                end
            end
        end
    end

    // --------------------
    // Read ports
    // --------------------
    // Both see the old word when a write hits the same index on the same edge.
    always_ff @(posedge clock) begin
        if (rd_en) begin
            rd_data <= mem[rd_idx];    // Held while the bus side stalls.
        end
    end

    always_ff @(posedge clock) begin
        dma_data <= mem[dma_idx];      // Free running, one cycle latency.
    end

endmodule : istore_mem

// File: istore_wr_if.sv
interface istore_wr_if;

    logic                              en;      // Write this cycle.
    logic [istore_pkg::istore_idx_w-1:0] idx;   // Word index.
    logic [axi_pkg::axi_data_w-1:0]    data;
    logic [axi_pkg::axi_strb_w-1:0]    strb;    // Byte enables.

    // The memory always accepts, so there is no ready.
    modport src (
        output en, idx, data, strb
    );

    modport mem (
        input en, idx, data, strb
    );

endinterface : istore_wr_if

// File: istore_pkg.sv
package istore_pkg;

    // --------------------
    // Store geometry
    // --------------------
    localparam int istore_depth = 256;             // Words in the store.
    localparam int istore_idx_w = $clog2(istore_depth);

    // Byte addresses at or above this limit fall outside the store.
    localparam logic [31:0] istore_byte_limit = 32'd1024;

endpackage : istore_pkg

// File: axi_pkg.sv
package axi_pkg;

    // --------------------
    // Bus widths
    // --------------------
    localparam int axi_data_w = 32;                // One instruction word per beat.
    localparam int axi_addr_w = 32;                // Byte address.
    localparam int axi_strb_w = axi_data_w / 8;    // One strobe per byte lane.
    localparam int axi_len_w  = 8;                 // Beats minus one, up to 256 beats.

    // --------------------
    // Burst types
    // --------------------
    // WRAP and the reserved code are refused by both controllers.
    localparam logic [1:0] burst_fixed = 2'b00;    // Same address every beat.
    localparam logic [1:0] burst_incr  = 2'b01;    // Address steps one word per beat.

    // --------------------
    // Responses
    // --------------------
    localparam logic [1:0] resp_okay   = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;    // Bad address or unsupported burst.

endpackage : axi_pkg
